//--- tb/scan_stimulus.txt
# base b0 b1 b2 b3 b4 b5 b6 b7 mode delay status io_out (hex except mode, delay, status)
# mode 0 ack, 1 error, 2 no answer; delay 0 means random; status 0 copied 1 executed 2 error 3 timeout
#
# Low region, copied whatever the code byte
000 01 ff ff 11 22 33 44 55 2 0 0 00
010 a5 5a 00 01 02 03 04 05 2 0 0 00
030 01 3c 0f 10 20 30 40 50 0 1 0 00
#
# Executable region with other codes
038 02 ff ff de ad be ef 00 2 0 0 00
040 00 12 34 56 78 9a bc de 2 0 0 00
#
# Executed commands
048 01 ab f0 c0 ff ee 00 11 0 3 1 a0
050 01 5c 0f 01 02 03 04 05 0 0 1 ac
#
# Executor error, then timeout, then a normal scan
058 01 ff 81 aa bb cc dd ee 1 4 2 ac
060 01 00 ff 99 88 77 66 55 2 0 3 ac
068 7e 00 ff 01 01 01 01 01 2 0 0 ac
070 01 00 0c 10 10 10 10 10 0 1 1 a0
#
# Error over an earlier echo keeps the old bytes
048 01 11 22 33 44 55 66 77 1 0 2 a0
#
# Empty mask, full mask, a second timeout
3f8 01 ff 00 01 02 03 04 05 0 2 1 a0
100 01 ff ff 00 00 00 00 00 0 50 1 ff
200 01 00 ff 00 00 00 00 00 2 0 3 ff
208 80 01 02 03 04 05 06 07 2 0 0 ff
210 01 00 55 aa aa aa aa aa 0 0 1 aa
#
# Just below the region boundary
037 01 ff ff 21 43 65 87 a9 0 1 0 aa

//--- scan_io.f
rtl/scan_pkg.sv
rtl/exec_if.sv
rtl/cmd_buffer.sv
rtl/io_executor.sv
rtl/cmd_scanner.sv
rtl/scan_io_top.sv
tb/tb_scan_io.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the scan engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f scan_io.f --top-module tb_scan_io -o tb_scan_io

# The run passes only when the testbench prints its pass line
output=$(./obj_dir/tb_scan_io)
echo "$output"
if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

//--- tb/tb_scan_io.sv
`timescale 1ns/10ps
`default_nettype none

module tb_scan_io;

	localparam int MAX_REC = 64;
	// Longest wait for one scan, executor timeout plus slack
	localparam int SCAN_LIMIT = scan_pkg::EXEC_TIMEOUT + 100;

	logic clk;
	logic rst;
	logic i_host_wr_en;
	logic [scan_pkg::ADDR_W-1:0] i_host_wr_addr;
	logic [scan_pkg::DATA_W-1:0] i_host_wr_data;
	logic [scan_pkg::ADDR_W-1:0] i_host_rd_addr;
	logic [scan_pkg::DATA_W-1:0] o_host_rd_data;
	logic i_scan_start;
	logic [scan_pkg::ADDR_W-1:0] i_scan_base;
	logic o_scan_done;
	scan_pkg::scan_status_e o_scan_status;
	logic [scan_pkg::IO_W-1:0] o_io_out;
	logic o_io_req;
	logic i_io_ack;
	logic i_io_err;

	// Records from the stimulus file
	logic [scan_pkg::ADDR_W-1:0] rec_base [MAX_REC];
	logic [scan_pkg::BLOCK_W-1:0] rec_block [MAX_REC];
	integer rec_mode [MAX_REC];
	integer rec_delay [MAX_REC];
	integer rec_status [MAX_REC];
	logic [scan_pkg::IO_W-1:0] rec_io [MAX_REC];
	integer n_rec;
	logic loaded;

	// Expected echo contents, zero until a block is echoed
	logic [scan_pkg::DATA_W-1:0] echo_model [2**scan_pkg::ADDR_W];

	integer check_errors;
	integer other_errors;
	integer seed;

	scan_io_top dut (
		.clk            (clk),
		.rst            (rst),
		.i_host_wr_en   (i_host_wr_en),
		.i_host_wr_addr (i_host_wr_addr),
		.i_host_wr_data (i_host_wr_data),
		.i_host_rd_addr (i_host_rd_addr),
		.o_host_rd_data (o_host_rd_data),
		.i_scan_start   (i_scan_start),
		.i_scan_base    (i_scan_base),
		.o_scan_done    (o_scan_done),
		.o_scan_status  (o_scan_status),
		.o_io_out       (o_io_out),
		.o_io_req       (o_io_req),
		.i_io_ack       (i_io_ack),
		.i_io_err       (i_io_err)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// Helpers
	// ==================================================

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			check_errors++;
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic load_records();
		integer fd;
		integer got;
		integer base, b0, b1, b2, b3, b4, b5, b6, b7;
		integer mode, delay, status, io;
		string line;
		fd = $fopen("tb/scan_stimulus.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the stimulus file tb/scan_stimulus.txt");
		end else begin
			while (!$feof(fd) && n_rec < MAX_REC) begin
				line = "";
				void'($fgets(line, fd));
				// Comment and blank lines are skipped
				if (line.len() > 0 && line[0] != "#") begin
					got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %d %d %h", base,
						b0, b1, b2, b3, b4, b5, b6, b7, mode, delay, status, io);
					if (got == 13) begin
						rec_base[n_rec] = base[scan_pkg::ADDR_W-1:0];
						rec_block[n_rec] = {b0[7:0], b1[7:0], b2[7:0], b3[7:0],
							b4[7:0], b5[7:0], b6[7:0], b7[7:0]};
						rec_mode[n_rec] = mode;
						rec_delay[n_rec] = delay;
						rec_status[n_rec] = status;
						rec_io[n_rec] = io[scan_pkg::IO_W-1:0];
						n_rec++;
					end
				end
			end
			$fclose(fd);
			if (n_rec == 0) begin
				other_errors++;
				$display("The stimulus file holds no test records");
			end
		end
	endtask

	// Host writes the 8 block bytes, byte 0 at the base
	task automatic write_block(input integer r);
		for (int i = 0; i < scan_pkg::BLOCK_BYTES; i++) begin
			@(posedge clk);
			i_host_wr_en <= 1'b1;
			i_host_wr_addr <= rec_base[r] + scan_pkg::ADDR_W'(i);
			i_host_wr_data <= rec_block[r][scan_pkg::BLOCK_W-1-8*i -: 8];
		end
		@(posedge clk);
		i_host_wr_en <= 1'b0;
	endtask

	// One scan, answering o_io_req as the record asks
	task automatic run_scan(input integer r);
		integer cycles;
		integer req_cycles;
		integer delay;
		logic done_seen;
		logic req_seen;
		logic answer;
		scan_pkg::scan_status_e status_got;
		logic [scan_pkg::IO_W-1:0] io_got;
		delay = rec_delay[r];
		// Delay 0 asks for a random ack delay of 1 to 50 cycles
		if (delay == 0) begin
			delay = 1 + (($random(seed) & 32'h7fffffff) % 50);
		end
		cycles = 0;
		req_cycles = 0;
		done_seen = 1'b0;
		req_seen = 1'b0;
		status_got = scan_pkg::ST_COPIED;
		io_got = '0;
		@(posedge clk);
		i_scan_start <= 1'b1;
		i_scan_base <= rec_base[r];
		@(posedge clk);
		i_scan_start <= 1'b0;
		while (!done_seen && cycles < SCAN_LIMIT) begin
			@(negedge clk);
			if (o_io_req) begin
				req_seen = 1'b1;
				req_cycles++;
			end
			if (o_scan_done) begin
				done_seen = 1'b1;
				status_got = o_scan_status;
				io_got = o_io_out;
			end
			// Single-cycle answer once the request has waited long enough
			answer = o_io_req && (req_cycles == delay);
			@(posedge clk);
			i_io_ack <= answer && (rec_mode[r] == 0);
			i_io_err <= answer && (rec_mode[r] == 1);
			cycles++;
		end
		if (!done_seen) begin
			other_errors++;
			$display("Record %0d at base %0h: no o_scan_done within %0d cycles",
				r, rec_base[r], SCAN_LIMIT);
		end else begin
			check_value($sformatf("record %0d status", r), rec_status[r], status_got);
			check_value($sformatf("record %0d io_out", r), rec_io[r], io_got);
			// Only executable blocks with the execute code reach the port
			check_value($sformatf("record %0d io_req seen", r),
				rec_status[r] != int'(scan_pkg::ST_COPIED), req_seen);
			@(negedge clk);
			check_value($sformatf("record %0d io_req after scan", r), 0, o_io_req);
		end
	endtask

	// Reads the echo buffer back over the host port
	task automatic check_echo(input integer r);
		logic [scan_pkg::ADDR_W-1:0] addr;
		// Copied and executed blocks land in the echo, failures leave it alone
		if (rec_status[r] == int'(scan_pkg::ST_COPIED) ||
			rec_status[r] == int'(scan_pkg::ST_EXECUTED)) begin
			for (int i = 0; i < scan_pkg::BLOCK_BYTES; i++) begin
				addr = rec_base[r] + scan_pkg::ADDR_W'(i);
				echo_model[addr] = rec_block[r][scan_pkg::BLOCK_W-1-8*i -: 8];
			end
		end
		for (int i = 0; i < scan_pkg::BLOCK_BYTES; i++) begin
			addr = rec_base[r] + scan_pkg::ADDR_W'(i);
			@(posedge clk);
			i_host_rd_addr <= addr;
			// Two-cycle read latency
			repeat (2) @(posedge clk);
			@(negedge clk);
			check_value($sformatf("record %0d echo byte %0d", r, i),
				echo_model[addr], o_host_rd_data);
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		rst = 1'b1;
		i_host_wr_en = 1'b0;
		i_host_wr_addr = '0;
		i_host_wr_data = '0;
		i_host_rd_addr = '0;
		i_scan_start = 1'b0;
		i_scan_base = '0;
		i_io_ack = 1'b0;
		i_io_err = 1'b0;
		check_errors = 0;
		other_errors = 0;
		seed = 14;
		n_rec = 0;
		loaded = 1'b0;
		for (int i = 0; i < 2**scan_pkg::ADDR_W; i++) begin
			echo_model[i] = '0;
		end
		load_records();
		loaded = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("reset scan_done", 0, o_scan_done);
		check_value("reset io_req", 0, o_io_req);
		check_value("reset io_out", 0, o_io_out);
		for (int r = 0; r < n_rec; r++) begin
			write_block(r);
			run_scan(r);
			check_echo(r);
		end
		$display("Summary: %0d records, %0d check failures, %0d other errors",
			n_rec, check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog sized from the number of records
	initial begin
		wait (loaded);
		repeat ((n_rec + 1) * SCAN_LIMIT) @(posedge clk);
		$display("Watchdog expired before all records finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/scan_io_top.sv
`timescale 1ns/10ps
`default_nettype none

module scan_io_top (
	input logic clk,
	input logic rst,

	// Host writes command blocks
	input logic i_host_wr_en,
	input logic [scan_pkg::ADDR_W-1:0] i_host_wr_addr,
	input logic [scan_pkg::DATA_W-1:0] i_host_wr_data,

	// Host reads echoed blocks, data two cycles later
	input logic [scan_pkg::ADDR_W-1:0] i_host_rd_addr,
	output logic [scan_pkg::DATA_W-1:0] o_host_rd_data,

	// Scan control
	input logic i_scan_start,
	input logic [scan_pkg::ADDR_W-1:0] i_scan_base,
	output logic o_scan_done,
	output scan_pkg::scan_status_e o_scan_status,

	// Output port
	output logic [scan_pkg::IO_W-1:0] o_io_out,
	output logic o_io_req,
	input logic i_io_ack,
	input logic i_io_err
);

	logic [scan_pkg::ADDR_W-1:0] cmd_rd_addr;
	logic [scan_pkg::DATA_W-1:0] cmd_rd_data;
	logic echo_wr_en;
	logic [scan_pkg::ADDR_W-1:0] echo_wr_addr;
	logic [scan_pkg::DATA_W-1:0] echo_wr_data;

	exec_if ex_bus ();

	// ================================================
	// Buffers
	// ================================================

	// Downlink, host in and scanner out
	cmd_buffer cmd_buf (
		.clk       (clk),
		.rst       (rst),
		.i_wr_en   (i_host_wr_en),
		.i_wr_addr (i_host_wr_addr),
		.i_wr_data (i_host_wr_data),
		.i_rd_addr (cmd_rd_addr),
		.o_rd_data (cmd_rd_data)
	);

	// Uplink, scanner in and host out
	cmd_buffer echo_buf (
		.clk       (clk),
		.rst       (rst),
		.i_wr_en   (echo_wr_en),
		.i_wr_addr (echo_wr_addr),
		.i_wr_data (echo_wr_data),
		.i_rd_addr (i_host_rd_addr),
		.o_rd_data (o_host_rd_data)
	);

	// ================================================
	// Scanner and executor
	// ================================================

	cmd_scanner scanner (
		.clk            (clk),
		.rst            (rst),
		.i_scan_start   (i_scan_start),
		.i_scan_base    (i_scan_base),
		.o_scan_done    (o_scan_done),
		.o_scan_status  (o_scan_status),
		.o_cmd_rd_addr  (cmd_rd_addr),
		.i_cmd_rd_data  (cmd_rd_data),
		.o_echo_wr_en   (echo_wr_en),
		.o_echo_wr_addr (echo_wr_addr),
		.o_echo_wr_data (echo_wr_data),
		.ex             (ex_bus.scanner)
	);

	io_executor executor (
		.clk      (clk),
		.rst      (rst),
		.ex       (ex_bus.executor),
		.o_io_out (o_io_out),
		.o_io_req (o_io_req),
		.i_io_ack (i_io_ack),
		.i_io_err (i_io_err)
	);

endmodule

`default_nettype wire

//--- rtl/cmd_scanner.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_scanner (
	input logic clk,
	input logic rst,

	// Host scan control
	input logic i_scan_start,
	input logic [scan_pkg::ADDR_W-1:0] i_scan_base,
	output logic o_scan_done,
	output scan_pkg::scan_status_e o_scan_status,

	// Command buffer read
	output logic [scan_pkg::ADDR_W-1:0] o_cmd_rd_addr,
	input logic [scan_pkg::DATA_W-1:0] i_cmd_rd_data,

	// Echo buffer write
	output logic o_echo_wr_en,
	output logic [scan_pkg::ADDR_W-1:0] o_echo_wr_addr,
	output logic [scan_pkg::DATA_W-1:0] o_echo_wr_data,

	// Executor request
	exec_if.scanner ex
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_DRAIN,
		S_CLASSIFY,
		S_EXEC,
		S_ECHO,
		S_DONE
	} state_e;

	state_e state;

	logic [scan_pkg::ADDR_W-1:0] base_q;
	logic exec_region_q;
	logic [scan_pkg::ADDR_W-1:0] rd_addr_q;
	logic [scan_pkg::CNT_W-1:0] byte_cnt;
	logic [scan_pkg::BUF_RD_LATENCY-1:0] rd_pipe;
	logic rd_issue;
	logic rd_capture;
	logic [scan_pkg::BLOCK_W-1:0] block_q;
	logic [scan_pkg::ADDR_W-1:0] echo_addr_q;
	logic [scan_pkg::TIMER_W-1:0] timer_q;
	scan_pkg::scan_status_e status_q;
	logic start_q;
	logic abort_q;
	logic [scan_pkg::IO_W-1:0] value_q;
	logic [scan_pkg::IO_W-1:0] mask_q;

	// Byte 0 is the code, byte 1 the value, byte 2 the mask
	logic [scan_pkg::DATA_W-1:0] code_byte;
	logic [scan_pkg::DATA_W-1:0] value_byte;
	logic [scan_pkg::DATA_W-1:0] mask_byte;

	assign code_byte = block_q[scan_pkg::BLOCK_W-1 -: scan_pkg::DATA_W];
	assign value_byte = block_q[scan_pkg::BLOCK_W-scan_pkg::DATA_W-1 -: scan_pkg::DATA_W];
	assign mask_byte = block_q[scan_pkg::BLOCK_W-2*scan_pkg::DATA_W-1 -: scan_pkg::DATA_W];

	// ================================================
	// Scan FSM
	// ================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			byte_cnt <= '0;
			timer_q <= '0;
			status_q <= scan_pkg::ST_COPIED;
			start_q <= 1'b0;
			abort_q <= 1'b0;
		end else begin
			// Request pulses last one cycle
			start_q <= 1'b0;
			abort_q <= 1'b0;
			case (state)
				S_IDLE: begin
					// Start is only seen here, so a busy scan ignores it
					if (i_scan_start) begin
						byte_cnt <= '0;
						state <= S_READ;
					end
				end
				S_READ: begin
					// One read per cycle, 8 in a row
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == scan_pkg::CNT_LAST) begin
						state <= S_DRAIN;
					end
				end
				S_DRAIN: begin
					// Wait until the last byte has landed in block_q
					if (rd_pipe == '0) begin
						state <= S_CLASSIFY;
					end
				end
				S_CLASSIFY: begin
					byte_cnt <= '0;
					timer_q <= '0;
					if (exec_region_q && code_byte == scan_pkg::CMD_EXECUTE) begin
						start_q <= 1'b1;
						state <= S_EXEC;
					end else begin
						status_q <= scan_pkg::ST_COPIED;
						state <= S_ECHO;
					end
				end
				S_EXEC: begin
					if (ex.done) begin
						status_q <= scan_pkg::ST_EXECUTED;
						state <= S_ECHO;
					end else if (ex.error) begin
						// Failed command leaves the echo untouched
						status_q <= scan_pkg::ST_EXEC_ERROR;
						state <= S_DONE;
					end else if (timer_q == scan_pkg::TIMER_LAST) begin
						// Pull the executor back to idle
						abort_q <= 1'b1;
						status_q <= scan_pkg::ST_TIMEOUT;
						state <= S_DONE;
					end else begin
						timer_q <= timer_q + 1'b1;
					end
				end
				S_ECHO: begin
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == scan_pkg::CNT_LAST) begin
						state <= S_DONE;
					end
				end
				S_DONE: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// ================================================
	// Address and block datapath
	// ================================================

	assign rd_issue = (state == S_READ);
	assign rd_capture = rd_pipe[scan_pkg::BUF_RD_LATENCY-1];

	// Tracks reads in flight through the buffer pipeline
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_pipe <= '0;
		end else begin
			rd_pipe <= {rd_pipe[scan_pkg::BUF_RD_LATENCY-2:0], rd_issue};
		end
	end

	// Base and region are latched when a scan is accepted
	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_scan_start) begin
			base_q <= i_scan_base;
			exec_region_q <= (i_scan_base >= scan_pkg::EXEC_REGION_BASE);
			rd_addr_q <= i_scan_base;
		end else if (rd_issue) begin
			rd_addr_q <= rd_addr_q + 1'b1;
		end
	end

	// Bytes enter at the bottom and leave at the top, byte 0 first
	always_ff @(posedge clk) begin
		if (rd_capture) begin
			block_q <= {block_q[scan_pkg::BLOCK_W-scan_pkg::DATA_W-1:0], i_cmd_rd_data};
		end else if (o_echo_wr_en) begin
			block_q <= {block_q[scan_pkg::BLOCK_W-scan_pkg::DATA_W-1:0],
				{scan_pkg::DATA_W{1'b0}}};
		end
	end

	// Echo lands at the same address as the command
	always_ff @(posedge clk) begin
		if (state == S_CLASSIFY) begin
			echo_addr_q <= base_q;
		end else if (o_echo_wr_en) begin
			echo_addr_q <= echo_addr_q + 1'b1;
		end
	end

	// Value and mask go out with the start pulse
	always_ff @(posedge clk) begin
		if (state == S_CLASSIFY) begin
			value_q <= value_byte;
			mask_q <= mask_byte;
		end
	end

	// ================================================
	// Outputs
	// ================================================

	assign o_cmd_rd_addr = rd_addr_q;
	assign o_echo_wr_en = (state == S_ECHO);
	assign o_echo_wr_addr = echo_addr_q;
	assign o_echo_wr_data = code_byte;

	// Status holds from the end of the scan until the next one
	assign o_scan_done = (state == S_DONE);
	assign o_scan_status = status_q;

	assign ex.start = start_q;
	assign ex.abort = abort_q;
	assign ex.value = value_q;
	assign ex.mask = mask_q;

endmodule

`default_nettype wire

//--- rtl/io_executor.sv
`timescale 1ns/10ps
`default_nettype none

module io_executor (
	input logic clk,
	input logic rst,

	// Request from the scanner
	exec_if.executor ex,

	// External output port and handshake
	output logic [scan_pkg::IO_W-1:0] o_io_out,
	output logic o_io_req,
	input logic i_io_ack,
	input logic i_io_err
);

	logic [scan_pkg::IO_W-1:0] value_q;
	logic [scan_pkg::IO_W-1:0] mask_q;
	logic [scan_pkg::IO_W-1:0] io_out_q;
	logic req_q;
	logic done_q;
	logic error_q;

	// ================================================
	// Request capture
	// ================================================

	// Proposed update is held for the whole transaction
	always_ff @(posedge clk) begin
		if (ex.start && !req_q) begin
			value_q <= ex.value;
			mask_q <= ex.mask;
		end
	end

	// ================================================
	// Transaction control
	// ================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			req_q <= 1'b0;
			io_out_q <= '0;
			done_q <= 1'b0;
			error_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			error_q <= 1'b0;
			if (ex.abort) begin
				// Abort wins over a late ack, port stays as it was
				req_q <= 1'b0;
			end else if (!req_q) begin
				// Only an idle executor takes a new request
				if (ex.start) begin
					req_q <= 1'b1;
				end
			end else if (i_io_ack) begin
				// Masked bits take the new value, the rest hold
				io_out_q <= (io_out_q & ~mask_q) | (value_q & mask_q);
				req_q <= 1'b0;
				done_q <= 1'b1;
			end else if (i_io_err) begin
				req_q <= 1'b0;
				error_q <= 1'b1;
			end
		end
	end

	assign o_io_out = io_out_q;
	assign o_io_req = req_q;
	assign ex.done = done_q;
	assign ex.error = error_q;

endmodule

`default_nettype wire

//--- rtl/cmd_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_buffer (
	input logic clk,
	input logic rst,

	// Write side
	input logic i_wr_en,
	input logic [scan_pkg::ADDR_W-1:0] i_wr_addr,
	input logic [scan_pkg::DATA_W-1:0] i_wr_data,

	// Read side, data two cycles after address
	input logic [scan_pkg::ADDR_W-1:0] i_rd_addr,
	output logic [scan_pkg::DATA_W-1:0] o_rd_data
);

	// ================================================
	// Storage
	// ================================================

	logic [scan_pkg::DATA_W-1:0] mem [2**scan_pkg::ADDR_W];
	logic [scan_pkg::ADDR_W-1:0] rd_addr_q;

	// Unwritten locations read back as zero
	initial begin
		for (int i = 0; i < 2**scan_pkg::ADDR_W; i++) begin
			mem[i] = '0;
		end
	end

	// Write lands at the clock edge
	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// ================================================
	// Two-stage read
	// ================================================

	// Stage 1 registers the address
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_addr_q <= '0;
		end else begin
			rd_addr_q <= i_rd_addr;
		end
	end

	// Stage 2 registers the data
	always_ff @(posedge clk) begin
		o_rd_data <= mem[rd_addr_q];
	end

endmodule

`default_nettype wire

//--- rtl/exec_if.sv
`timescale 1ns/10ps
`default_nettype none

interface exec_if;

	// Request side, owned by the scanner
	logic start;
	logic [scan_pkg::IO_W-1:0] value;
	logic [scan_pkg::IO_W-1:0] mask;
	logic abort;

	// Result side, one pulse per request unless aborted
	logic done;
	logic error;

	modport scanner (
		output start, value, mask, abort,
		input done, error
	);

	modport executor (
		input start, value, mask, abort,
		output done, error
	);

endinterface

`default_nettype wire

//--- rtl/scan_pkg.sv
`default_nettype none

package scan_pkg;

	// ================================================
	// Buffer geometry
	// ================================================

	// 1024 bytes per buffer
	localparam int ADDR_W = 10;
	localparam int DATA_W = 8;

	// One command block is 8 bytes, code byte first
	localparam int BLOCK_BYTES = 8;
	localparam int BLOCK_W = BLOCK_BYTES * DATA_W;
	localparam int CNT_W = $clog2(BLOCK_BYTES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLOCK_BYTES - 1);

	// Cycles from read address to read data in cmd_buffer
	localparam int BUF_RD_LATENCY = 2;

	// ================================================
	// Command decode
	// ================================================

	// Blocks based below this address are only copied
	localparam logic [ADDR_W-1:0] EXEC_REGION_BASE = ADDR_W'(56);
	localparam logic [DATA_W-1:0] CMD_EXECUTE = 8'h01;

	// Executor wait limit in cycles
	localparam int EXEC_TIMEOUT = 1000;
	localparam int TIMER_W = $clog2(EXEC_TIMEOUT + 1);
	localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(EXEC_TIMEOUT - 1);

	// Output port width
	localparam int IO_W = 8;

	// Result of one scan
	typedef enum logic [1:0] {
		ST_COPIED     = 2'd0,
		ST_EXECUTED   = 2'd1,
		ST_EXEC_ERROR = 2'd2,
		ST_TIMEOUT    = 2'd3
	} scan_status_e;

endpackage

`default_nettype wire
